// ==== tb.f ====
+incdir+dv
source/decode_pkg.sv
source/decode_ifs.sv
source/op_classifier.sv
source/operand_extractor.sv
source/decode_register.sv
source/instr_decoder.sv
dv/tb_instr_decoder.sv

// ==== dv/decode_ref.svh ====
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

typedef struct packed {
   op_e           op;
   decode_flags_t flags;
   fmt_e          fmt;
   logic [4:0]    rd;
   logic [4:0]    rs1;
   logic [4:0]    rs2;
   logic [31:0]   imm;
   logic [31:0]   pc;
} ref_t;

function automatic logic [31:0] make_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                       logic [2:0] f3, logic [4:0] rd, logic [6:0] opc);
   return {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] make_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                       logic [4:0] rd, logic [6:0] opc);
   return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] make_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                       logic [2:0] f3, logic [6:0] opc);
   return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
endfunction

function automatic logic [31:0] make_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                       logic [2:0] f3);
   return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
endfunction

function automatic logic [31:0] make_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
   return {imm, rd, opc};
endfunction

function automatic logic [31:0] make_j(logic [20:0] imm, logic [4:0] rd);
   return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
endfunction

function automatic op_e ref_op(logic [31:0] w);
   logic [6:0] f7;
   logic [2:0] f3;
   logic       r2z;
   op_e        op;
   f7  = w[31:25];
   f3  = w[14:12];
   r2z = (w[24:20] == 5'd0);
   op  = op_illegal;
   case (w[6:0])
      opc_lui:      op = op_lui;
      opc_auipc:    op = op_auipc;
      opc_jal:      op = op_jal;
      opc_jalr:     op = (f3 == 3'd0) ? op_jalr : op_illegal;
      opc_load_fp:  op = (f3 == 3'd2) ? op_flw : op_illegal;
      opc_store_fp: op = (f3 == 3'd2) ? op_fsw : op_illegal;
      opc_branch: begin
         if (f3 == 3'd0) op = op_beq;
         if (f3 == 3'd1) op = op_bne;
         if (f3 >= 3'd4) op = op_e'(op_blt + (f3 - 3'd4));
      end
      opc_load: begin
         if (f3 <= 3'd2) op = op_e'(op_lb + f3);
         if (f3 == 3'd4) op = op_lbu;
         if (f3 == 3'd5) op = op_lhu;
      end
      opc_store:
         if (f3 <= 3'd2) op = op_e'(op_sb + f3);
      opc_op_imm: begin
         case (f3)
            3'd0: op = op_addi;
            3'd2: op = op_slti;
            3'd3: op = op_sltiu;
            3'd4: op = op_xori;
            3'd6: op = op_ori;
            3'd7: op = op_andi;
            3'd1: op = (f7 == 7'h00) ? op_slli : op_illegal;
            3'd5: op = (f7 == 7'h00) ? op_srli : (f7 == 7'h20) ? op_srai : op_illegal;
         endcase
      end
      opc_op: begin
         case ({f7, f3})
            {7'h00, 3'd0}: op = op_add;
            {7'h20, 3'd0}: op = op_sub;
            {7'h00, 3'd1}: op = op_sll;
            {7'h00, 3'd2}: op = op_slt;
            {7'h00, 3'd3}: op = op_sltu;
            {7'h00, 3'd4}: op = op_xor;
            {7'h00, 3'd5}: op = op_srl;
            {7'h20, 3'd5}: op = op_sra;
            {7'h00, 3'd6}: op = op_or;
            {7'h00, 3'd7}: op = op_and;
            default: if (f7 == 7'h01) op = op_e'(op_mul + f3);
         endcase
      end
      opc_op_fp: begin
         if (f7 == 7'h10 && f3 <= 3'd2) op = op_e'(op_fsgnj + f3);
         if (f7 == 7'h50 && f3 == 3'd0) op = op_fle;
         if (f7 == 7'h50 && f3 == 3'd2) op = op_feq;
         if (f3 == 3'd0) begin
            case (f7)
               7'h00: op = op_fadd;
               7'h04: op = op_fsub;
               7'h08: op = op_fmul;
               7'h0c: op = op_fdiv;
               7'h2c: if (r2z) op = op_fsqrt;
               7'h60: if (r2z) op = op_fcvt_w_s;
               7'h68: if (r2z) op = op_fcvt_s_w;
               7'h70: if (r2z) op = op_fmv_x_w;
               7'h78: if (r2z) op = op_fmv_w_x;
               default: ;
            endcase
         end
      end
      default: op = op_illegal;
   endcase
   return op;
endfunction

function automatic ref_t decode_ref(logic [31:0] w, logic [31:0] pc);
   ref_t r;
   logic fw;
   r.op  = ref_op(w);
   fw    = r.op inside {op_flw, op_fadd, op_fsub, op_fmul, op_fdiv, op_fsqrt, op_fsgnj,
                        op_fsgnjn, op_fsgnjx, op_fcvt_s_w, op_fmv_w_x};
   r.flags.is_load        = r.op inside {[op_lb:op_lhu], op_flw};
   r.flags.is_store       = r.op inside {[op_sb:op_sw], op_fsw};
   r.flags.is_cond_branch = r.op inside {[op_beq:op_bgeu]};
   r.flags.is_jump        = r.op inside {op_jal, op_jalr};
   r.flags.is_float       = r.op inside {[op_flw:op_fmv_w_x]};
   r.flags.writes_freg    = fw;
   r.flags.writes_reg     = !(r.flags.is_cond_branch || r.flags.is_store || fw ||
                              r.op == op_illegal);
   r.flags.uses_reg       = r.op inside {[op_lui:op_remu], op_flw, op_fcvt_s_w, op_fmv_w_x};
   r.flags.uses_freg      = r.flags.is_float &&
                            !(r.op inside {op_flw, op_fcvt_s_w, op_fmv_w_x});
   case (w[6:0])
      opc_op, opc_op_fp:                           r.fmt = fmt_r;
      opc_jalr, opc_load, opc_op_imm, opc_load_fp: r.fmt = fmt_i;
      opc_store, opc_store_fp:                     r.fmt = fmt_s;
      opc_branch:                                  r.fmt = fmt_b;
      opc_lui, opc_auipc:                          r.fmt = fmt_u;
      opc_jal:                                     r.fmt = fmt_j;
      default:                                     r.fmt = fmt_none;
   endcase
   r.rd  = (r.fmt inside {fmt_s, fmt_b, fmt_none}) ? 5'd0 : w[11:7];
   r.rs1 = (r.fmt inside {fmt_u, fmt_j, fmt_none}) ? 5'd0 : w[19:15];
   r.rs2 = (r.fmt inside {fmt_r, fmt_s, fmt_b}) ? w[24:20] : 5'd0;
   case (r.fmt)
      fmt_i:   r.imm = {{21{w[31]}}, w[30:20]};
      fmt_s:   r.imm = {{21{w[31]}}, w[30:25], w[11:7]};
      fmt_b:   r.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      fmt_u:   r.imm = {w[31:12], 12'd0};
      fmt_j:   r.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      default: r.imm = 32'd0;
   endcase
   r.pc = pc;
   return r;
endfunction

`endif

// ==== dv/tb_instr_decoder.sv ====
`timescale 1ns/1ps

module tb_instr_decoder import decode_pkg::*; ();

   `include "decode_ref.svh"

   // strobes per test for the watchdog
   localparam int n_per_op      = 3;
   localparam int n_ops         = 61;
   localparam int n_imm         = 12;
   localparam int n_comb        = 6;
   localparam int n_btb         = 24;
   localparam int n_rand        = 240;
   localparam int total_strobes = n_per_op * n_ops + n_imm + n_comb + n_btb + n_rand;
   localparam int max_tries     = 100000;
   // gaps can double the cycle count per strobe
   localparam time timeout      = total_strobes * 40ns + 5us;

   logic          clk;
   logic          rstn;
   logic          enabled;
   logic [31:0]   pc;
   logic [31:0]   instr_raw;
   logic          completed;
   op_e           op;
   decode_flags_t flags;
   logic [4:0]    rd;
   logic [4:0]    rs1_q;
   logic [4:0]    rs2_q;
   logic [31:0]   imm;
   logic [31:0]   pc_q;
   logic [4:0]    rs1;
   logic [4:0]    rs2;

   logic [31:0] word_q[$];
   logic [31:0] pc_q_exp[$];
   logic [31:0] rng_state = 32'hd18f_45ca;
   logic [31:0] next_pc = 32'h0000_1000;
   logic        en_at_edge = 1'b0;
   logic        have_last = 1'b0;
   ref_t        last_exp;
   int          n_checks = 0;
   int          n_errors = 0;

   instr_decoder instr_decoder_inst (
      .clk       (clk),
      .rstn      (rstn),
      .enabled   (enabled),
      .pc        (pc),
      .instr_raw (instr_raw),
      .completed (completed),
      .op        (op),
      .flags     (flags),
      .rd        (rd),
      .rs1_q     (rs1_q),
      .rs2_q     (rs2_q),
      .imm       (imm),
      .pc_q      (pc_q),
      .rs1       (rs1),
      .rs2       (rs2)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic logic [31:0] xorshift();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   function automatic logic [31:0] ref_imm(logic [31:0] w);
      ref_t e;
      e = decode_ref(w, 32'd0);
      return e.imm;
   endfunction

   task automatic check_op(string what, op_e got, op_e exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("ERROR at %0t: %s got %s expected %s", $time, what, got.name(), exp.name());
      end
   endtask

   task automatic check_flags(string what, decode_flags_t got, decode_flags_t exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("ERROR at %0t: %s got %b expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_w32(string what, logic [31:0] got, logic [31:0] exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("ERROR at %0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_w5(string what, logic [4:0] got, logic [4:0] exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("ERROR at %0t: %s got %0d expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic issue(logic [31:0] w);
      ref_t e;
      @(posedge clk);
      #2;
      enabled   = 1'b1;
      instr_raw = w;
      pc        = next_pc;
      word_q.push_back(w);
      pc_q_exp.push_back(next_pc);
      next_pc   = next_pc + 32'd4;
      e = decode_ref(w, pc);
      #1;
      // early indices in the same cycle
      check_w5("rs1 comb", rs1, e.rs1);
      check_w5("rs2 comb", rs2, e.rs2);
   endtask

   task automatic idle();
      @(posedge clk);
      #2;
      enabled   = 1'b0;
      instr_raw = xorshift();
   endtask

   task automatic drain(string name, int start);
      idle();
      wait (word_q.size() == 0);
      @(negedge clk);
      $display("%s: %0d errors", name, n_errors - start);
   endtask

   // random candidate biased toward supported encodings
   function automatic logic [31:0] candidate();
      logic [6:0] opcs[12];
      logic [6:0] f7s[13];
      logic [31:0] r;
      logic [4:0] r2;
      opcs = '{opc_lui, opc_auipc, opc_jal, opc_jalr, opc_branch, opc_load, opc_store,
               opc_op_imm, opc_op, opc_load_fp, opc_store_fp, opc_op_fp};
      f7s  = '{7'h00, 7'h20, 7'h01, 7'h04, 7'h08, 7'h0c, 7'h2c, 7'h10, 7'h50,
               7'h60, 7'h68, 7'h70, 7'h78};
      r  = xorshift();
      r2 = r[31] ? 5'd0 : r[24:20];
      return make_r(f7s[xorshift() % 13], r2, r[19:15], r[14:12], r[11:7],
                    opcs[xorshift() % 12]);
   endfunction

   // strobe seen at each rising edge
   initial begin
      forever begin
         @(posedge clk);
         en_at_edge = enabled && !rstn;
      end
   end

   // outputs are stable at the falling edge
   initial begin
      ref_t        e;
      logic [31:0] w;
      logic [31:0] p;
      forever begin
         @(negedge clk);
         if (!rstn) begin
            n_checks++;
            if (completed !== en_at_edge) begin
               n_errors++;
               $display("ERROR at %0t: completed is %b one cycle after strobe %b",
                        $time, completed, en_at_edge);
            end
            if (completed === 1'b1) begin
               if (word_q.size() == 0) begin
                  n_errors++;
                  $display("completed went high at %0t with no word in flight", $time);
               end else begin
                  w = word_q.pop_front();
                  p = pc_q_exp.pop_front();
                  e = decode_ref(w, p);
                  check_op("op", op, e.op);
                  check_flags("flags", flags, e.flags);
                  check_w5("rd", rd, e.rd);
                  check_w5("rs1_q", rs1_q, e.rs1);
                  check_w5("rs2_q", rs2_q, e.rs2);
                  check_w32("imm", imm, e.imm);
                  check_w32("pc_q", pc_q, e.pc);
                  last_exp  = e;
                  have_last = 1'b1;
               end
            end else if (have_last) begin
               check_op("held op", op, last_exp.op);
               check_flags("held flags", flags, last_exp.flags);
               check_w5("held rd", rd, last_exp.rd);
               check_w5("held rs1_q", rs1_q, last_exp.rs1);
               check_w5("held rs2_q", rs2_q, last_exp.rs2);
               check_w32("held imm", imm, last_exp.imm);
               check_w32("held pc_q", pc_q, last_exp.pc);
            end
         end
      end
   end

   initial begin
      #(timeout);
      $display("timeout: the run did not finish within %0t", timeout);
      $display("Simulation failed");
      $finish;
   end

   initial begin
      int          start;
      logic [31:0] w;
      logic [31:0] r;
      int          tries;
      op_e         want;
      rstn      = 1'b1;
      enabled   = 1'b0;
      pc        = 32'd0;
      instr_raw = 32'd0;
      repeat (2) @(posedge clk);
      #2;
      rstn = 1'b0;

      // reset values
      start = n_errors;
      @(negedge clk);
      check_w32("completed after reset", {31'd0, completed}, 32'd0);
      check_op("op after reset", op, op_illegal);
      check_flags("flags after reset", flags, '0);
      $display("reset values: %0d errors", n_errors - start);

      // every supported op
      start = n_errors;
      for (int k = 1; k <= n_ops; k++) begin
         want = op_e'(k);
         for (int n = 0; n < n_per_op; n++) begin
            tries = 0;
            do begin
               w = candidate();
               tries++;
            end while (ref_op(w) != want && tries < max_tries);
            if (ref_op(w) != want) begin
               n_errors++;
               $display("could not build a word for %s", want.name());
            end
            issue(w);
            if (xorshift() & 1)
               idle();
         end
      end
      drain("supported ops", start);

      // immediates with bit 31 set and clear
      start = n_errors;
      for (int s = 0; s < 2; s++) begin
         r = xorshift();
         r[31] = s[0];
         issue(make_i(r[31:20], r[19:15], 3'd0, r[11:7], opc_op_imm));
         check_w32("ref i imm", ref_imm(instr_raw), {{20{r[31]}}, r[31:20]});
         issue(make_s(r[31:20], r[24:20], r[19:15], 3'd2, opc_store));
         check_w32("ref s imm", ref_imm(instr_raw), {{20{r[31]}}, r[31:20]});
         issue(make_b({r[31:20], 1'b0}, r[24:20], r[19:15], 3'd0));
         check_w32("ref b imm", ref_imm(instr_raw), {{19{r[31]}}, r[31:20], 1'b0});
         issue(make_u(r[31:12], r[11:7], opc_lui));
         check_w32("ref u imm", ref_imm(instr_raw), {r[31:12], 12'd0});
         issue(make_j({r[31:12], 1'b0}, r[11:7]));
         check_w32("ref j imm", ref_imm(instr_raw), {{11{r[31]}}, r[31:12], 1'b0});
         issue(make_r(7'h00, r[24:20], r[19:15], 3'd0, r[11:7], opc_op));
         check_w32("ref r imm", ref_imm(instr_raw), 32'd0);
      end
      drain("immediates", start);

      // early indices are zero where the format has no source
      start = n_errors;
      for (int s = 0; s < 2; s++) begin
         r = xorshift() | 32'h01f0_801e;
         issue(make_u(r[31:12], r[11:7], opc_auipc));
         check_w5("u rs1 zero", rs1, 5'd0);
         check_w5("u rs2 zero", rs2, 5'd0);
         issue(make_j(r[20:0], r[11:7]));
         check_w5("j rs1 zero", rs1, 5'd0);
         check_w5("j rs2 zero", rs2, 5'd0);
         issue(make_i(r[31:20], r[19:15], 3'd2, r[11:7], opc_load));
         check_w5("i rs2 zero", rs2, 5'd0);
      end
      drain("combinational indices", start);

      // back to back then with gaps
      start = n_errors;
      for (int n = 0; n < 16; n++)
         issue(candidate());
      repeat (3) idle();
      for (int n = 0; n < 8; n++) begin
         issue(candidate());
         repeat (1 + xorshift() % 3) idle();
      end
      drain("back to back", start);

      // random words and float words with rs2 set where it must be zero
      start = n_errors;
      for (int n = 0; n < 200; n++)
         issue(xorshift());
      for (int n = 0; n < 40; n++) begin
         r = xorshift();
         w = make_r(n[0] ? 7'h2c : 7'h70, r[24:20] | 5'd1, r[19:15], 3'd0, r[11:7],
                    opc_op_fp);
         check_op("ref nonzero rs2", ref_op(w), op_illegal);
         issue(w);
      end
      drain("random words", start);

      $display("%0d checks, %0d errors", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// ==== source/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder import decode_pkg::*; (
   input  logic          clk,
   input  logic          rstn,
   input  logic          enabled,
   input  logic [31:0]   pc,
   input  logic [31:0]   instr_raw,
   output logic          completed,
   output op_e           op,
   output decode_flags_t flags,
   output logic [4:0]    rd,
   output logic [4:0]    rs1_q,
   output logic [4:0]    rs2_q,
   output logic [31:0]   imm,
   output logic [31:0]   pc_q,
   output logic [4:0]    rs1,
   output logic [4:0]    rs2
);

   class_if   cls_bus ();
   operand_if opr_bus ();

   op_classifier op_classifier_inst (
      .instr_raw (instr_raw),
      .cls       (cls_bus.producer)
   );

   // early source indices for the register file
   operand_extractor operand_extractor_inst (
      .instr_raw (instr_raw),
      .opr       (opr_bus.producer),
      .rs1       (rs1),
      .rs2       (rs2)
   );

   decode_register decode_register_inst (
      .clk       (clk),
      .rstn      (rstn),
      .enabled   (enabled),
      .pc        (pc),
      .cls       (cls_bus.consumer),
      .opr       (opr_bus.consumer),
      .completed (completed),
      .op        (op),
      .flags     (flags),
      .rd        (rd),
      .rs1_q     (rs1_q),
      .rs2_q     (rs2_q),
      .imm       (imm),
      .pc_q      (pc_q)
   );

endmodule

// ==== source/decode_register.sv ====
`timescale 1ns/1ps

module decode_register import decode_pkg::*; (
   input  logic          clk,
   input  logic          rstn,
   input  logic          enabled,
   input  logic [31:0]   pc,
   class_if.consumer     cls,
   operand_if.consumer   opr,
   output logic          completed,
   output op_e           op,
   output decode_flags_t flags,
   output logic [4:0]    rd,
   output logic [4:0]    rs1_q,
   output logic [4:0]    rs2_q,
   output logic [31:0]   imm,
   output logic [31:0]   pc_q
);

   // rstn high means reset
   always_ff @(posedge clk) begin
      if (rstn) begin
         completed <= 1'b0;
         op        <= op_illegal;
         flags     <= '0;
         rd        <= 5'd0;
         rs1_q     <= 5'd0;
         rs2_q     <= 5'd0;
         imm       <= 32'd0;
         pc_q      <= 32'd0;
      end else if (enabled) begin
         completed <= 1'b1;
         op        <= cls.op;
         flags     <= cls.flags;
         rd        <= opr.rd;
         rs1_q     <= opr.rs1;
         rs2_q     <= opr.rs2;
         imm       <= opr.imm;
         pc_q      <= pc;
      end else begin
         // hold the last decode
         completed <= 1'b0;
      end
   end

endmodule

// ==== source/operand_extractor.sv ====
`timescale 1ns/1ps

module operand_extractor import decode_pkg::*; (
   input  instr_word_u instr_raw,
   operand_if.producer opr,
   output logic [4:0]  rs1,
   output logic [4:0]  rs2
);

   fmt_e              fmt;
   instr_reg_view_t   rv;
   instr_upper_view_t uv;

   assign rv = instr_raw.r;
   assign uv = instr_raw.u;

   // format depends on the major opcode only
   always_comb begin
      case (rv.opcode)
         opc_op, opc_op_fp:                          fmt = fmt_r;
         opc_jalr, opc_load, opc_op_imm, opc_load_fp: fmt = fmt_i;
         opc_store, opc_store_fp:                    fmt = fmt_s;
         opc_branch:                                 fmt = fmt_b;
         opc_lui, opc_auipc:                         fmt = fmt_u;
         opc_jal:                                    fmt = fmt_j;
         default:                                    fmt = fmt_none;
      endcase
   end

   assign opr.rd = (fmt inside {fmt_r, fmt_i, fmt_u, fmt_j}) ? rv.rd : 5'd0;
   assign rs1    = (fmt inside {fmt_r, fmt_i, fmt_s, fmt_b}) ? rv.rs1 : 5'd0;
   assign rs2    = (fmt inside {fmt_r, fmt_s, fmt_b}) ? rv.rs2 : 5'd0;

   assign opr.rs1 = rs1;
   assign opr.rs2 = rs2;

   // sign bit is always instr[31]
   always_comb begin
      case (fmt)
         fmt_i: opr.imm = {{20{rv.funct7[6]}}, rv.funct7, rv.rs2};
         fmt_s: opr.imm = {{20{rv.funct7[6]}}, rv.funct7, rv.rd};
         fmt_b: opr.imm = {{20{rv.funct7[6]}}, rv.rd[0], rv.funct7[5:0], rv.rd[4:1], 1'b0};
         fmt_u: opr.imm = {uv.imm_hi, 12'd0};
         fmt_j: opr.imm = {{12{uv.imm_hi[19]}}, uv.imm_hi[7:0], uv.imm_hi[8],
                           uv.imm_hi[18:9], 1'b0};
         default: opr.imm = 32'd0;
      endcase
   end

endmodule

// ==== source/op_classifier.sv ====
`timescale 1ns/1ps

module op_classifier import decode_pkg::*; (
   input instr_word_u instr_raw,
   class_if.producer  cls
);

   logic [6:0]    opcode;
   logic [6:0]    f7;
   logic [2:0]    f3;
   logic          f3_zero;
   logic          rs2_zero;
   logic          freg_wr;
   op_e           op;
   decode_flags_t flags;

   assign opcode   = instr_raw.r.opcode;
   assign f7       = instr_raw.r.funct7;
   assign f3       = instr_raw.r.funct3;
   assign f3_zero  = (f3 == 3'b000);
   assign rs2_zero = (instr_raw.r.rs2 == 5'd0);

   always_comb begin
      op = op_illegal;
      case (opcode)
         opc_lui:      op = op_lui;
         opc_auipc:    op = op_auipc;
         opc_jal:      op = op_jal;
         opc_jalr:     if (f3_zero) op = op_jalr;
         opc_load_fp:  if (f3 == 3'b010) op = op_flw;
         opc_store_fp: if (f3 == 3'b010) op = op_fsw;
         opc_branch: begin
            case (f3)
               3'b000: op = op_beq;
               3'b001: op = op_bne;
               3'b100: op = op_blt;
               3'b101: op = op_bge;
               3'b110: op = op_bltu;
               3'b111: op = op_bgeu;
               default: op = op_illegal;
            endcase
         end
         opc_load: begin
            case (f3)
               3'b000: op = op_lb;
               3'b001: op = op_lh;
               3'b010: op = op_lw;
               3'b100: op = op_lbu;
               3'b101: op = op_lhu;
               default: op = op_illegal;
            endcase
         end
         opc_store: begin
            case (f3)
               3'b000: op = op_sb;
               3'b001: op = op_sh;
               3'b010: op = op_sw;
               default: op = op_illegal;
            endcase
         end
         opc_op_imm: begin
            case (f3)
               3'b000: op = op_addi;
               3'b010: op = op_slti;
               3'b011: op = op_sltiu;
               3'b100: op = op_xori;
               3'b110: op = op_ori;
               3'b111: op = op_andi;
               3'b001: if (f7 == f7_base) op = op_slli;
               3'b101: begin
                  // shift amount sits in rs2, funct7 picks logical or arithmetic
                  if (f7 == f7_base)
                     op = op_srli;
                  else if (f7 == f7_alt)
                     op = op_srai;
               end
            endcase
         end
         opc_op: begin
            case (f7)
               f7_base: begin
                  case (f3)
                     3'b000: op = op_add;
                     3'b001: op = op_sll;
                     3'b010: op = op_slt;
                     3'b011: op = op_sltu;
                     3'b100: op = op_xor;
                     3'b101: op = op_srl;
                     3'b110: op = op_or;
                     3'b111: op = op_and;
                  endcase
               end
               f7_alt: begin
                  if (f3 == 3'b000)
                     op = op_sub;
                  else if (f3 == 3'b101)
                     op = op_sra;
               end
               f7_mext: begin
                  case (f3)
                     3'b000: op = op_mul;
                     3'b001: op = op_mulh;
                     3'b010: op = op_mulhsu;
                     3'b011: op = op_mulhu;
                     3'b100: op = op_div;
                     3'b101: op = op_divu;
                     3'b110: op = op_rem;
                     3'b111: op = op_remu;
                  endcase
               end
               default: op = op_illegal;
            endcase
         end
         opc_op_fp: begin
            // rounding mode field must be zero for arithmetic and conversions
            case (f7)
               f7_fadd:     if (f3_zero) op = op_fadd;
               f7_fsub:     if (f3_zero) op = op_fsub;
               f7_fmul:     if (f3_zero) op = op_fmul;
               f7_fdiv:     if (f3_zero) op = op_fdiv;
               f7_fsqrt:    if (f3_zero && rs2_zero) op = op_fsqrt;
               f7_fcvt_w_s: if (f3_zero && rs2_zero) op = op_fcvt_w_s;
               f7_fcvt_s_w: if (f3_zero && rs2_zero) op = op_fcvt_s_w;
               f7_fmv_x_w:  if (f3_zero && rs2_zero) op = op_fmv_x_w;
               f7_fmv_w_x:  if (f3_zero && rs2_zero) op = op_fmv_w_x;
               f7_fsgnj: begin
                  case (f3)
                     3'b000: op = op_fsgnj;
                     3'b001: op = op_fsgnjn;
                     3'b010: op = op_fsgnjx;
                     default: op = op_illegal;
                  endcase
               end
               f7_fcmp: begin
                  if (f3 == 3'b000)
                     op = op_fle;
                  else if (f3 == 3'b010)
                     op = op_feq;
               end
               default: op = op_illegal;
            endcase
         end
         default: op = op_illegal;
      endcase
   end

   // float ops whose result lands in the float file
   assign freg_wr = op inside {op_flw, op_fadd, op_fsub, op_fmul, op_fdiv, op_fsqrt,
                               op_fsgnj, op_fsgnjn, op_fsgnjx, op_fcvt_s_w, op_fmv_w_x};

   always_comb begin
      flags.is_load        = op inside {op_lb, op_lh, op_lw, op_lbu, op_lhu, op_flw};
      flags.is_store       = op inside {op_sb, op_sh, op_sw, op_fsw};
      flags.is_cond_branch = op inside {op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu};
      flags.is_jump        = op inside {op_jal, op_jalr};
      flags.is_float       = freg_wr ||
                             op inside {op_fsw, op_fcvt_w_s, op_fmv_x_w, op_feq, op_fle};
      flags.writes_freg    = freg_wr;
      flags.writes_reg     = !(flags.is_cond_branch || flags.is_store || freg_wr ||
                               op == op_illegal);
      flags.uses_reg       = (!flags.is_float && op != op_illegal) ||
                             op inside {op_flw, op_fcvt_s_w, op_fmv_w_x};
      flags.uses_freg      = op inside {op_fsw, op_fadd, op_fsub, op_fmul, op_fdiv,
                                        op_fsqrt, op_fsgnj, op_fsgnjn, op_fsgnjx,
                                        op_fcvt_w_s, op_feq, op_fle, op_fmv_x_w};
   end

   assign cls.op    = op;
   assign cls.flags = flags;

endmodule

// ==== source/decode_ifs.sv ====
`timescale 1ns/1ps

// classifier result
interface class_if import decode_pkg::*; ();

   op_e           op;
   decode_flags_t flags;

   modport producer (
      output op,
      output flags
   );

   modport consumer (
      input op,
      input flags
   );

endinterface

// register indices and immediate
interface operand_if ();

   logic [4:0]  rd;
   logic [4:0]  rs1;
   logic [4:0]  rs2;
   logic [31:0] imm;

   modport producer (
      output rd,
      output rs1,
      output rs2,
      output imm
   );

   modport consumer (
      input rd,
      input rs1,
      input rs2,
      input imm
   );

endinterface

// ==== source/decode_pkg.sv ====
package decode_pkg;

   // major opcodes
   localparam logic [6:0] opc_lui      = 7'b0110111;
   localparam logic [6:0] opc_auipc    = 7'b0010111;
   localparam logic [6:0] opc_jal      = 7'b1101111;
   localparam logic [6:0] opc_jalr     = 7'b1100111;
   localparam logic [6:0] opc_branch   = 7'b1100011;
   localparam logic [6:0] opc_load     = 7'b0000011;
   localparam logic [6:0] opc_store    = 7'b0100011;
   localparam logic [6:0] opc_op_imm   = 7'b0010011;
   localparam logic [6:0] opc_op       = 7'b0110011;
   localparam logic [6:0] opc_load_fp  = 7'b0000111;
   localparam logic [6:0] opc_store_fp = 7'b0100111;
   localparam logic [6:0] opc_op_fp    = 7'b1010011;

   // integer funct7 groups
   localparam logic [6:0] f7_base = 7'b0000000;
   localparam logic [6:0] f7_alt  = 7'b0100000;
   localparam logic [6:0] f7_mext = 7'b0000001;

   // float funct7 groups
   localparam logic [6:0] f7_fadd     = 7'b0000000;
   localparam logic [6:0] f7_fsub     = 7'b0000100;
   localparam logic [6:0] f7_fmul     = 7'b0001000;
   localparam logic [6:0] f7_fdiv     = 7'b0001100;
   localparam logic [6:0] f7_fsqrt    = 7'b0101100;
   localparam logic [6:0] f7_fsgnj    = 7'b0010000;
   localparam logic [6:0] f7_fcmp     = 7'b1010000;
   localparam logic [6:0] f7_fcvt_w_s = 7'b1100000;
   localparam logic [6:0] f7_fcvt_s_w = 7'b1101000;
   localparam logic [6:0] f7_fmv_x_w  = 7'b1110000;
   localparam logic [6:0] f7_fmv_w_x  = 7'b1111000;

   typedef enum logic [7:0] {
      op_illegal,
      // rv32i
      op_lui, op_auipc, op_jal, op_jalr,
      op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
      op_lb, op_lh, op_lw, op_lbu, op_lhu,
      op_sb, op_sh, op_sw,
      op_addi, op_slti, op_sltiu, op_xori, op_ori, op_andi,
      op_slli, op_srli, op_srai,
      op_add, op_sub, op_sll, op_slt, op_sltu,
      op_xor, op_srl, op_sra, op_or, op_and,
      // rv32m
      op_mul, op_mulh, op_mulhsu, op_mulhu,
      op_div, op_divu, op_rem, op_remu,
      // rv32f
      op_flw, op_fsw,
      op_fadd, op_fsub, op_fmul, op_fdiv, op_fsqrt,
      op_fsgnj, op_fsgnjn, op_fsgnjx,
      op_fcvt_w_s, op_fmv_x_w, op_feq, op_fle,
      op_fcvt_s_w, op_fmv_w_x
   } op_e;

   typedef enum logic [2:0] {
      fmt_r,
      fmt_i,
      fmt_s,
      fmt_b,
      fmt_u,
      fmt_j,
      fmt_none
   } fmt_e;

   typedef struct packed {
      logic is_load;
      logic is_store;
      logic is_cond_branch;
      logic is_jump;
      logic is_float;
      logic writes_reg;
      logic writes_freg;
      logic uses_reg;
      logic uses_freg;
   } decode_flags_t;

   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } instr_reg_view_t;

   // U and J formats keep their immediate in the top 20 bits
   typedef struct packed {
      logic [19:0] imm_hi;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } instr_upper_view_t;

   typedef union packed {
      instr_reg_view_t   r;
      instr_upper_view_t u;
   } instr_word_u;

endpackage
